/* design/ch1_params.svh */
`ifndef CH1_PARAMS_SVH
`define CH1_PARAMS_SVH

// frame sequencer step length, kept short for simulation
`define CH1_FRAME_DIV 32

// clocks per frequency timer decrement
`define CH1_TONE_DIV 2

// clocks between produced samples
`define CH1_SAMPLE_DIV 16

// mixer side buffer depth
`define CH1_CREDITS 4

`define CH1_ADDR_NR10 3'd0 // sweep
`define CH1_ADDR_NR11 3'd1 // duty, length
`define CH1_ADDR_NR12 3'd2 // volume
`define CH1_ADDR_NR13 3'd3 // freq low
`define CH1_ADDR_NR14 3'd4 // trigger, freq high

`endif

/* design/ch1_pkg.sv */
package ch1_pkg;

	typedef logic [10:0] freq_t;
	typedef logic [1:0]  duty_t;
	typedef logic [7:0]  duty_wave_t; // one bit per eighth of a period

	typedef struct packed {
		logic       unused;
		logic [2:0] period;
		logic       negate;
		logic [2:0] shift;
	} sweep_reg_t;

	typedef struct packed {
		duty_t      duty;
		logic [5:0] length;
	} duty_len_reg_t;

	typedef struct packed {
		logic [3:0] init_vol;
		logic [3:0] envelope; // envelope not modeled
	} vol_reg_t;

	typedef struct packed {
		logic       trigger;
		logic       length_en;
		logic [2:0] unused;
		logic [2:0] freq_hi;
	} ctrl_reg_t;

	// same write byte, decoded by address
	typedef union packed {
		sweep_reg_t    sweep;
		duty_len_reg_t duty_len;
		vol_reg_t      vol;
		ctrl_reg_t     ctrl;
		logic [7:0]    raw;
	} reg_byte_u;

	function automatic duty_wave_t duty_wave(duty_t duty);
		case (duty)
			2'd0:    return 8'b0000_0001; // 12.5%
			2'd1:    return 8'b1000_0001; // 25%
			2'd2:    return 8'b1000_0111; // 50%
			default: return 8'b0111_1110; // 75%
		endcase
	endfunction

endpackage

/* design/ch1_cfg_if.sv */
`timescale 1ns/1ps

interface ch1_cfg_if;
	import ch1_pkg::*;

	logic [2:0] sweep_period;
	logic       sweep_negate;
	logic [2:0] sweep_shift;
	freq_t      freq;
	duty_t      duty;
	logic [5:0] length_load;
	logic       length_en;
	logic [3:0] volume;
	logic       trigger;   // one cycle pulse
	logic       freq_wr;   // sweep write-back strobe
	freq_t      freq_new;

	modport regs (
		output sweep_period, sweep_negate, sweep_shift, freq, duty,
		output length_load, length_en, volume, trigger,
		input  freq_wr, freq_new
	);

	modport sweep (
		input  sweep_period, sweep_negate, sweep_shift, freq, trigger,
		output freq_wr, freq_new
	);

	modport tone (
		input  freq, duty, length_load, length_en, volume, trigger
	);

endinterface

/* design/ch1_regs.sv */
`timescale 1ns/1ps
`include "ch1_params.svh"

module ch1_regs (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               wr,
	input  logic [2:0]         addr,
	input  ch1_pkg::reg_byte_u wdata,
	output logic [7:0]         rdata,
	ch1_cfg_if.regs            cfg
);
	import ch1_pkg::*;

	sweep_reg_t    nr10;
	duty_len_reg_t nr11;
	logic [3:0]    volume;
	freq_t         freq;
	logic          length_en;
	logic          trigger;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			nr10      <= '0;
			nr11      <= '0;
			volume    <= 4'd0;
			freq      <= '0;
			length_en <= 1'b0;
			trigger   <= 1'b0;
		end else begin
			trigger <= 1'b0;
			if (wr) begin
				case (addr)
					`CH1_ADDR_NR10: nr10 <= wdata.sweep;
					`CH1_ADDR_NR11: nr11 <= wdata.duty_len;
					`CH1_ADDR_NR12: volume <= wdata.vol.init_vol;
					`CH1_ADDR_NR13: freq[7:0] <= wdata.raw;
					`CH1_ADDR_NR14: begin
						length_en  <= wdata.ctrl.length_en;
						freq[10:8] <= wdata.ctrl.freq_hi;
						trigger    <= wdata.ctrl.trigger; // not stored
					end
					default: ;
				endcase
			end
			if (cfg.freq_wr)
				freq <= cfg.freq_new; // sweep wins over bus
		end
	end

	always_comb begin
		case (addr)
			`CH1_ADDR_NR10: rdata = {1'b0, nr10.period, nr10.negate, nr10.shift};
			`CH1_ADDR_NR11: rdata = nr11;
			`CH1_ADDR_NR12: rdata = {volume, 4'd0};
			`CH1_ADDR_NR13: rdata = freq[7:0];
			`CH1_ADDR_NR14: rdata = {1'b0, length_en, 3'd0, freq[10:8]};
			default:        rdata = 8'h00;
		endcase
	end

	assign cfg.sweep_period = nr10.period;
	assign cfg.sweep_negate = nr10.negate;
	assign cfg.sweep_shift  = nr10.shift;
	assign cfg.freq         = freq;
	assign cfg.duty         = nr11.duty;
	assign cfg.length_load  = nr11.length;
	assign cfg.length_en    = length_en;
	assign cfg.volume       = volume;
	assign cfg.trigger      = trigger;

endmodule

/* design/ch1_sweep.sv */
`timescale 1ns/1ps

module ch1_sweep (
	input  logic     clk,
	input  logic     rst_n,
	ch1_cfg_if.sweep cfg,
	input  logic     sweep_tick,
	output logic     sweep_overflow
);
	import ch1_pkg::*;

	freq_t       shadow;
	freq_t       delta;
	logic [11:0] sum;
	logic [3:0]  timer;
	logic [3:0]  reload;
	logic        enabled;
	logic        check_pend; // overflow check after trigger
	logic        upd_pend;   // timer expired
	logic        calc;
	logic        ovf;
	logic        write_back;
	logic        freq_wr;
	freq_t       freq_new;

	// period 0 still runs the timer as 8
	assign reload = (cfg.sweep_period == 3'd0) ? 4'd8 : {1'b0, cfg.sweep_period};

	assign delta = shadow >> cfg.sweep_shift;
	assign sum   = cfg.sweep_negate ? ({1'b0, shadow} - {1'b0, delta})
	                                : ({1'b0, shadow} + {1'b0, delta});
	assign ovf   = sum[11]; // above 2047, only when adding
	assign calc  = check_pend || upd_pend;

	assign write_back = upd_pend && !ovf && (cfg.sweep_shift != 3'd0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer          <= 4'd0;
			enabled        <= 1'b0;
			check_pend     <= 1'b0;
			upd_pend       <= 1'b0;
			sweep_overflow <= 1'b0;
			freq_wr        <= 1'b0;
		end else begin
			check_pend <= 1'b0;
			upd_pend   <= 1'b0;
			freq_wr    <= 1'b0;
			if (cfg.trigger) begin
				timer          <= reload;
				enabled        <= (cfg.sweep_period != 3'd0) || (cfg.sweep_shift != 3'd0);
				check_pend     <= cfg.sweep_shift != 3'd0;
				sweep_overflow <= 1'b0;
			end else begin
				if (sweep_tick && enabled && !sweep_overflow) begin
					if (timer <= 4'd1) begin
						timer    <= reload;
						upd_pend <= cfg.sweep_period != 3'd0;
					end else begin
						timer <= timer - 4'd1;
					end
				end
				if (calc && ovf)
					sweep_overflow <= 1'b1; // held until next trigger
				if (write_back)
					freq_wr <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cfg.trigger)
			shadow <= cfg.freq;
		else if (write_back)
			shadow <= sum[10:0];
		if (write_back)
			freq_new <= sum[10:0];
	end

	assign cfg.freq_wr  = freq_wr;
	assign cfg.freq_new = freq_new;

endmodule

/* design/ch1_tone.sv */
`timescale 1ns/1ps
`include "ch1_params.svh"

module ch1_tone (
	input  logic       clk,
	input  logic       rst_n,
	ch1_cfg_if.tone    cfg,
	input  logic       sweep_overflow,
	output logic       sweep_tick,
	output logic [3:0] sample,
	output logic       sample_strobe,
	output logic       ch_on
);
	import ch1_pkg::*;

	localparam int FRAME_W  = $clog2(`CH1_FRAME_DIV);
	localparam int TONE_W   = $clog2(`CH1_TONE_DIV);
	localparam int SAMPLE_W = $clog2(`CH1_SAMPLE_DIV);

	logic [FRAME_W-1:0]  frame_cnt;
	logic [2:0]          step;
	logic                frame_end;
	logic                length_tick;
	logic [TONE_W-1:0]   tone_cnt;
	logic                tone_en;
	logic [11:0]         ftimer;
	logic [2:0]          duty_pos;
	logic [6:0]          len_cnt;
	logic [SAMPLE_W-1:0] sample_cnt;
	logic                sample_end;
	duty_wave_t          wave;
	logic [3:0]          level;

	assign frame_end   = frame_cnt == FRAME_W'(`CH1_FRAME_DIV - 1);
	assign length_tick = frame_end && !step[0]; // even steps
	assign tone_en     = tone_cnt == TONE_W'(`CH1_TONE_DIV - 1);
	assign sample_end  = sample_cnt == SAMPLE_W'(`CH1_SAMPLE_DIV - 1);
	assign wave        = duty_wave(cfg.duty);
	assign level       = (ch_on && wave[duty_pos]) ? cfg.volume : 4'd0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_cnt     <= '0;
			step          <= 3'd0;
			sweep_tick    <= 1'b0;
			tone_cnt      <= '0;
			sample_cnt    <= '0;
			sample_strobe <= 1'b0;
		end else begin
			frame_cnt     <= frame_end ? '0 : frame_cnt + 1'b1;
			tone_cnt      <= tone_en ? '0 : tone_cnt + 1'b1;
			sample_cnt    <= sample_end ? '0 : sample_cnt + 1'b1;
			sample_strobe <= sample_end;
			sweep_tick    <= frame_end && (step[1:0] == 2'b10); // steps 2 and 6
			if (frame_end)
				step <= step + 3'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ftimer   <= 12'd0;
			duty_pos <= 3'd0;
		end else if (cfg.trigger) begin
			ftimer <= 12'd2048 - {1'b0, cfg.freq};
		end else if (tone_en) begin
			if (ftimer == 12'd0) begin
				ftimer   <= 12'd2048 - {1'b0, cfg.freq};
				duty_pos <= duty_pos + 3'd1;
			end else begin
				ftimer <= ftimer - 12'd1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ch_on   <= 1'b0;
			len_cnt <= 7'd0;
		end else if (cfg.trigger) begin
			ch_on   <= 1'b1;
			len_cnt <= 7'd64 - {1'b0, cfg.length_load};
		end else if (sweep_overflow) begin
			ch_on <= 1'b0;
		end else if (length_tick && cfg.length_en && len_cnt != 7'd0) begin
			len_cnt <= len_cnt - 7'd1;
			if (len_cnt == 7'd1)
				ch_on <= 1'b0; // length expired
		end
	end

	always_ff @(posedge clk) begin
		if (sample_end)
			sample <= level;
	end

endmodule

/* design/ch1_sample_out.sv */
`timescale 1ns/1ps
`include "ch1_params.svh"

module ch1_sample_out (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [3:0] sample,
	input  logic       sample_strobe,
	input  logic       credit_return,
	output logic [3:0] sample_data,
	output logic       sample_valid
);
	localparam int CW = $clog2(`CH1_CREDITS + 1);

	logic [CW-1:0] credits;
	logic          pending;
	logic [3:0]    hold;

	assign sample_valid = pending && (credits != '0);
	assign sample_data  = hold;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CW'(`CH1_CREDITS);
			pending <= 1'b0;
		end else begin
			if (sample_strobe)
				pending <= 1'b1; // newer sample replaces old one
			else if (sample_valid)
				pending <= 1'b0;
			case ({credit_return, sample_valid})
				2'b10: begin
					if (credits != CW'(`CH1_CREDITS))
						credits <= credits + 1'b1;
				end
				2'b01:   credits <= credits - 1'b1;
				default: ; // return and spend cancel
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (sample_strobe)
			hold <= sample;
	end

endmodule

/* design/ch1_top.sv */
`timescale 1ns/1ps

module ch1_top (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       wr,
	input  logic [2:0] addr,
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	input  logic       credit_return,
	output logic [3:0] sample_data,
	output logic       sample_valid,
	output logic       ch_on
);
	logic       sweep_tick;
	logic       sweep_overflow;
	logic [3:0] sample;
	logic       sample_strobe;

	ch1_cfg_if cfg ();

	ch1_regs ch1_regs_i (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (wr),
		.addr  (addr),
		.wdata (wdata),
		.rdata (rdata),
		.cfg   (cfg.regs)
	);

	ch1_sweep ch1_sweep_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.cfg            (cfg.sweep),
		.sweep_tick     (sweep_tick),
		.sweep_overflow (sweep_overflow)
	);

	ch1_tone ch1_tone_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.cfg            (cfg.tone),
		.sweep_overflow (sweep_overflow),
		.sweep_tick     (sweep_tick),
		.sample         (sample),
		.sample_strobe  (sample_strobe),
		.ch_on          (ch_on)
	);

	ch1_sample_out ch1_sample_out_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.sample        (sample),
		.sample_strobe (sample_strobe),
		.credit_return (credit_return),
		.sample_data   (sample_data),
		.sample_valid  (sample_valid)
	);

endmodule

/* tests/ch1_clkgen.sv */
`timescale 1ns/1ps

module ch1_clkgen (
	output logic clk
);
	initial clk = 1'b0;

	always #10 clk = ~clk; // 20 ns period

endmodule

/* tests/ch1_chk.sv */
`timescale 1ns/1ps
`include "ch1_params.svh"

module ch1_chk #(
	parameter int CW = $clog2(`CH1_CREDITS + 1)
) (
	input logic clk,
	input logic rst_n,
	input logic credit_return,
	input logic sample_valid,
	input logic sweep_overflow,
	input logic trigger,
	input logic ch_on
);

	logic [CW:0] balance; // credits left as seen on the ports

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			balance <= (CW+1)'(`CH1_CREDITS);
		else
			balance <= balance + (CW+1)'(credit_return) - (CW+1)'(sample_valid);
	end

	credits_in_range: assert property (
		@(posedge clk) disable iff (!rst_n) balance <= (CW+1)'(`CH1_CREDITS)
	) else $error("credit count above the mixer depth");

	valid_needs_credit: assert property (
		@(posedge clk) disable iff (!rst_n) sample_valid |-> balance != '0
	) else $error("sample sent with no credit left");

	// overflow flag holds the channel off until the next trigger
	off_after_overflow: assert property (
		@(posedge clk) disable iff (!rst_n) sweep_overflow && !trigger |=> !ch_on
	) else $error("channel back on after overflow without a trigger");

endmodule

/* tests/ch1_tb.sv */
`timescale 1ns/1ps
`include "ch1_params.svh"

module ch1_tb;
	localparam int N_TESTS     = 10;
	localparam int WAIT_FRAMES = 64; // two sweep steps of up to 8 ticks of 4 frames
	localparam int LIMIT       = N_TESTS * WAIT_FRAMES * `CH1_FRAME_DIV + 20000;

	logic       clk;
	logic       rst_n;
	logic       wr;
	logic [2:0] addr;
	logic [7:0] wdata;
	logic [7:0] rdata;
	logic       credit_return;
	logic [3:0] sample_data;
	logic       sample_valid;
	logic       ch_on;

	logic [31:0] seed = 32'd81;
	logic [3:0]  vol = 4'd0;
	logic        quiet = 1'b0; // only zero samples expected
	logic        hold_credits = 1'b0;
	int          owed = 0;     // credits still to hand back
	int          n_sent = 0;
	int          n_held = 0;
	int          n_vol = 0;
	int          n_zero = 0;

	ch1_clkgen clkgen_i (.clk(clk));

	ch1_top ch1_top_i (.*);

	bind ch1_top ch1_chk ch1_chk_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.credit_return  (credit_return),
		.sample_valid   (sample_valid),
		.sweep_overflow (sweep_overflow),
		.trigger        (ch1_regs_i.trigger),
		.ch_on          (ch_on)
	);

	function automatic logic [15:0] rnd();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:16];
	endfunction

	function automatic logic [11:0] sweep_step(logic [10:0] f, logic [2:0] sh, logic neg);
		logic [11:0] d;
		d = {1'b0, f >> sh};
		return neg ? {1'b0, f} - d : {1'b0, f} + d;
	endfunction

	function automatic logic overflows(logic [11:0] s);
		return s > 12'd2047;
	endfunction

	// unused bits read back as zero
	function automatic logic [7:0] read_view(logic [2:0] a, logic [7:0] d);
		case (a)
			`CH1_ADDR_NR10: return {1'b0, d[6:0]};
			`CH1_ADDR_NR12: return {d[7:4], 4'd0};
			`CH1_ADDR_NR14: return {1'b0, d[6], 3'd0, d[2:0]};
			default:        return d;
		endcase
	endfunction

	task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic write_reg(logic [2:0] a, logic [7:0] d);
		@(posedge clk);
		wr    <= 1'b1;
		addr  <= a;
		wdata <= d;
		@(posedge clk);
		wr <= 1'b0;
	endtask

	task automatic read_reg(logic [2:0] a, output logic [7:0] d);
		@(posedge clk);
		addr <= a;
		@(negedge clk);
		d = rdata;
	endtask

	task automatic read_freq(output logic [10:0] f);
		logic [7:0] lo;
		logic [7:0] hi;
		logic [7:0] lo2;
		do begin
			read_reg(`CH1_ADDR_NR13, lo);
			read_reg(`CH1_ADDR_NR14, hi);
			read_reg(`CH1_ADDR_NR13, lo2);
		end while (lo != lo2); // write-back landed between the reads
		f = {hi[2:0], lo};
	endtask

	task automatic wait_samples(int n);
		int target;
		target = n_sent + n;
		wait (n_sent >= target);
	endtask

	task automatic start(logic [10:0] f, logic [2:0] per, logic neg, logic [2:0] sh);
		write_reg(`CH1_ADDR_NR10, 8'h00);
		write_reg(`CH1_ADDR_NR14, 8'h80); // retrigger so the old sweep stops
		write_reg(`CH1_ADDR_NR13, f[7:0]);
		write_reg(`CH1_ADDR_NR10, {1'b0, per, neg, sh});
		write_reg(`CH1_ADDR_NR14, {1'b1, 4'd0, f[10:8]});
	endtask

	task automatic sweep_test(logic neg);
		logic [15:0] r;
		logic [10:0] f;
		logic [2:0]  sh;
		logic [2:0]  per;
		logic [11:0] s1;
		logic [11:0] s2;
		logic [10:0] got;
		do begin
			r  = rnd();
			f  = r[10:0];
			sh = (r[13:11] == 3'd0) ? 3'd1 : r[13:11];
			s1 = sweep_step(f, sh, neg);
			s2 = sweep_step(s1[10:0], sh, neg);
		end while (overflows(s1) || overflows(s2) || s1[10:0] == f || s2[10:0] == s1[10:0]);
		r   = rnd();
		per = (r[2:0] == 3'd0) ? 3'd1 : r[2:0];
		start(f, per, neg, sh);
		do read_freq(got); while (got == f);
		compare("freq", 32'(got), 32'(s1[10:0]));
		do read_freq(got); while (got == s1[10:0]);
		compare("freq", 32'(got), 32'(s2[10:0]));
	endtask

	task automatic overflow_test();
		logic [15:0] r;
		logic [10:0] f;
		logic [2:0]  sh;
		do begin
			r  = rnd();
			f  = r[10:0];
			sh = (r[13:11] == 3'd0) ? 3'd1 : r[13:11];
		end while (!overflows(sweep_step(f, sh, 1'b0)));
		start(f, 3'd1, 1'b0, sh);
		repeat (3) @(posedge clk);
		@(negedge clk);
		compare("ch_on", 32'(ch_on), 32'd0);
		repeat (2 * `CH1_SAMPLE_DIV) @(posedge clk);
		quiet = 1'b1; // sample held from before has been replaced
		wait_samples(16);
		compare("ch_on", 32'(ch_on), 32'd0);
		quiet = 1'b0;
	endtask

	task automatic credit_test();
		int k;
		hold_credits = 1'b1;
		wait (owed == 0);
		repeat (6 * `CH1_SAMPLE_DIV) @(posedge clk);
		compare("samples_without_credit", n_held, `CH1_CREDITS);
		for (k = 1; k <= 3; k++) begin
			owed = owed + 1;
			wait (owed == 0);
			repeat (3 * `CH1_SAMPLE_DIV) @(posedge clk);
			compare("samples_without_credit", n_held, `CH1_CREDITS + k);
		end
		hold_credits = 1'b0;
		owed = owed + `CH1_CREDITS; // refill the sender
	endtask

	task automatic amplitude_test();
		logic [15:0] r;
		r = rnd();
		write_reg(`CH1_ADDR_NR11, 8'h80);
		start(11'd2045 - 11'(r[1:0]), 3'd0, 1'b0, 3'd0); // short wave period
		wait_samples(2);
		n_vol  = 0;
		n_zero = 0;
		wait_samples(16);
		compare("ch_on", 32'(ch_on), 32'd1);
		compare("volume_samples_seen", 32'(n_vol != 0), 32'd1);
		compare("zero_samples_seen", 32'(n_zero != 0), 32'd1);
	endtask

	always @(negedge clk) begin
		logic [3:0] expected;
		if (rst_n && sample_valid) begin
			expected = (quiet || sample_data == 4'd0) ? 4'd0 : vol;
			compare("sample_data", 32'(sample_data), 32'(expected));
			n_sent = n_sent + 1;
			if (sample_data == 4'd0)
				n_zero = n_zero + 1;
			else
				n_vol = n_vol + 1;
			if (hold_credits)
				n_held = n_held + 1;
			else
				owed = owed + 1;
		end
	end

	// hands credits back after a random gap
	initial begin
		logic [15:0] r;
		credit_return = 1'b0;
		forever begin
			wait (owed > 0);
			r = rnd();
			repeat (int'(r[2:0])) @(posedge clk);
			@(posedge clk);
			credit_return <= 1'b1;
			owed = owed - 1;
			@(posedge clk);
			credit_return <= 1'b0;
		end
	end

	initial begin
		logic [15:0] r;
		logic [7:0]  d;
		logic [7:0]  got;
		int          a;
		rst_n = 1'b0;
		wr    = 1'b0;
		addr  = 3'd0;
		wdata = 8'h00;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) begin
			for (a = 0; a < 5; a++) begin
				r = rnd();
				d = (a == 4) ? {1'b0, r[6:0]} : r[7:0]; // no trigger
				write_reg(3'(a), d);
				read_reg(3'(a), got);
				compare("rdata", 32'(got), 32'(read_view(3'(a), d)));
			end
		end
		r   = rnd();
		vol = (r[3:0] == 4'd0) ? 4'd9 : r[3:0];
		write_reg(`CH1_ADDR_NR12, {vol, 4'd0});
		write_reg(`CH1_ADDR_NR11, 8'h80);
		repeat (3) sweep_test(1'b0);
		repeat (3) sweep_test(1'b1);
		repeat (2) overflow_test();
		credit_test();
		amplitude_test();
		$display("TEST RESULT: PASS");
		$finish;
	end

	initial begin
		repeat (LIMIT) @(posedge clk);
		$display("timeout: tests did not finish within %0d clock cycles", LIMIT);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

/* compile.f */
+incdir+design
design/ch1_pkg.sv
design/ch1_cfg_if.sv
design/ch1_regs.sv
design/ch1_sweep.sv
design/ch1_tone.sv
design/ch1_sample_out.sv
design/ch1_top.sv
tests/ch1_clkgen.sv
tests/ch1_chk.sv
tests/ch1_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= ch1_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
